//--- verilog/aes_sbox_pkg.sv
// AES byte substitution definitions

package aes_sbox_pkg;

    // ------------------------------------------------------------
    // Opcode
    // ------------------------------------------------------------

    // Forward S-box for encryption, inverse S-box for decryption
    typedef enum logic {
        OP_SUB     = 1'b0,
        OP_INV_SUB = 1'b1
    } sbox_op_e;

    // ------------------------------------------------------------
    // State geometry
    // ------------------------------------------------------------

    // One AES state is a 4x4 byte matrix
    localparam int STATE_BYTES = 16;

    // Flat state width, byte 0 in the low lane
    localparam int STATE_W = STATE_BYTES * 8;

    // ------------------------------------------------------------
    // Affine map constants
    // ------------------------------------------------------------

    // Added after the forward affine matrix (FIPS-197 c)
    localparam logic [7:0] AFFINE_C = 8'h63;

    // Added after the inverse affine matrix
    localparam logic [7:0] INV_AFFINE_C = 8'h05;

endpackage

//--- verilog/pprm_inverter.sv
// PPRM GF(2^8) inverter
`timescale 1ns/1ps

module pprm_inverter (
    input  logic [7:0] x,
    output logic [7:0] y
);

    // ------------------------------------------------------------
    // AND-XOR building block
    // ------------------------------------------------------------

    // Product modulo x^8 + x^4 + x^3 + x + 1
    // Pure AND terms folded by XOR, so every output bit is a PPRM sum
    function automatic logic [7:0] gf_mul(
        input logic [7:0] a,
        input logic [7:0] b
    );
        logic [14:0] p;
        p = '0;
        // Partial products, one AND term per bit pair
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                p[i + j] = p[i + j] ^ (a[i] & b[j]);
            end
        end
        // Fold the high half back, top bit first
        // x^8 = x^4 + x^3 + x + 1
        for (int k = 14; k >= 8; k--) begin
            p[k - 4] = p[k - 4] ^ p[k];
            p[k - 5] = p[k - 5] ^ p[k];
            p[k - 7] = p[k - 7] ^ p[k];
            p[k - 8] = p[k - 8] ^ p[k];
        end
        return p[7:0];
    endfunction

    // ------------------------------------------------------------
    // Stage 1: conjugate and norm
    // ------------------------------------------------------------

    // GF(2^8) seen as a quadratic extension of its GF(2^4) subfield
    // Conjugate of x over GF(2^4) is x^16
    logic [7:0] x_2;
    logic [7:0] x_4;
    logic [7:0] x_8;
    logic [7:0] x_16;

    // Norm x^17 always lands in the GF(2^4) subfield
    logic [7:0] norm;

    // Squaring is linear, four in a row give the conjugate
    assign x_2  = gf_mul(x, x);
    assign x_4  = gf_mul(x_2, x_2);
    assign x_8  = gf_mul(x_4, x_4);
    assign x_16 = gf_mul(x_8, x_8);

    // Element times its conjugate
    assign norm = gf_mul(x, x_16);

    // ------------------------------------------------------------
    // Stage 2: inversion in GF(2^4)
    // ------------------------------------------------------------

    // Subfield has order 15, so n^-1 = n^14 = n^2 * n^4 * n^8
    logic [7:0] n_2;
    logic [7:0] n_4;
    logic [7:0] n_8;
    logic [7:0] n_6;
    logic [7:0] n_inv;

    assign n_2   = gf_mul(norm, norm);
    assign n_4   = gf_mul(n_2, n_2);
    assign n_8   = gf_mul(n_4, n_4);
    assign n_6   = gf_mul(n_2, n_4);
    assign n_inv = gf_mul(n_6, n_8);

    // Zero norm stays zero here, which gives the 0 -> 0 case

    // ------------------------------------------------------------
    // Stage 3: back to GF(2^8)
    // ------------------------------------------------------------

    // x^-1 = x^16 * (x^17)^-1
    // Result already in the polynomial basis of the AES field
    assign y = gf_mul(x_16, n_inv);

endmodule

//--- verilog/sbox_pprm.sv
// Single byte PPRM S-box
`timescale 1ns/1ps

module sbox_pprm
    import aes_sbox_pkg::*;
(
    input  logic [7:0] byte_in,
    input  sbox_op_e   op,
    output logic [7:0] byte_out
);

    // ------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------

    // Forward direction selected
    logic       enc;

    // Forward affine network
    logic [7:0] aff_in;
    logic [7:0] aff_out;

    // Inverse affine network
    logic [7:0] inv_aff_in;
    logic [7:0] inv_aff_out;

    // Shared inverter
    logic [7:0] inv_in;
    logic [7:0] inv_out;

    // ------------------------------------------------------------
    // Data steering
    // ------------------------------------------------------------

    assign enc = (op == OP_SUB);

    // Idle network held at zero to cut switching
    assign aff_in     = enc ? inv_out : 8'h00;
    assign inv_aff_in = enc ? 8'h00 : byte_in;

    // Encrypt inverts first, decrypt inverts last
    assign inv_in   = enc ? byte_in : inv_aff_out;
    assign byte_out = enc ? aff_out : inv_out;

    // ------------------------------------------------------------
    // Affine XOR networks
    // ------------------------------------------------------------

    // b[i] = a[i] ^ a[i+4] ^ a[i+5] ^ a[i+6] ^ a[i+7] ^ c[i]
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            aff_out[i] = aff_in[i] ^ aff_in[(i + 4) % 8] ^ aff_in[(i + 5) % 8]
                       ^ aff_in[(i + 6) % 8] ^ aff_in[(i + 7) % 8] ^ AFFINE_C[i];
        end
    end

    // a[i] = b[i+2] ^ b[i+5] ^ b[i+7] ^ d[i]
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            inv_aff_out[i] = inv_aff_in[(i + 2) % 8] ^ inv_aff_in[(i + 5) % 8]
                           ^ inv_aff_in[(i + 7) % 8] ^ INV_AFFINE_C[i];
        end
    end

    // ------------------------------------------------------------
    // Multiplicative inverse
    // ------------------------------------------------------------

    pprm_inverter u_inverter (
        .x (inv_in),
        .y (inv_out)
    );

endmodule

//--- verilog/state_fifo.sv
// Credit-returning state buffer
`timescale 1ns/1ps

module state_fifo
    import aes_sbox_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  sbox_op_e           in_op,
    input  logic [STATE_W-1:0] in_state,
    input  logic               fifo_pop,
    output logic               fifo_valid,
    output sbox_op_e           fifo_op,
    output logic [STATE_W-1:0] fifo_state,
    output logic               in_credit
);

    // Pointer width, at least one bit
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // Count holds 0 up to FIFO_DEPTH
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    logic [STATE_W-1:0] state_mem [FIFO_DEPTH];
    sbox_op_e           op_mem    [FIFO_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    // Upstream credits keep writes within depth, no full check
    always_ff @(posedge clk) begin
        if (in_valid) begin
            state_mem[wr_ptr] <= in_state;
            op_mem[wr_ptr]    <= in_op;
        end
    end

    // ------------------------------------------------------------
    // Pointers, count, credit return
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            // Circular wrap at the last slot
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({in_valid, fifo_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit per freed slot, one cycle after the pop
            in_credit <= fifo_pop;
        end
    end

    // Head entry
    assign fifo_valid = (count != '0);
    assign fifo_op    = op_mem[rd_ptr];
    assign fifo_state = state_mem[rd_ptr];

endmodule

//--- verilog/sub_bytes_pipe.sv
// SubBytes datapath and output credits
`timescale 1ns/1ps

module sub_bytes_pipe
    import aes_sbox_pkg::*;
#(
    parameter int OUT_CREDITS = 2
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fifo_valid,
    input  sbox_op_e           fifo_op,
    input  logic [STATE_W-1:0] fifo_state,
    input  logic               out_credit,
    output logic               fifo_pop,
    output logic               out_valid,
    output sbox_op_e           out_op,
    output logic [STATE_W-1:0] out_state
);

    // Headroom for grants beyond the initial pool
    localparam int CRED_W = $clog2(OUT_CREDITS + 256);

    // ------------------------------------------------------------
    // Byte lanes
    // ------------------------------------------------------------

    logic [STATE_W-1:0] sub_state;

    // All 16 lanes share the head opcode
    for (genvar i = 0; i < STATE_BYTES; i++) begin : g_lane
        sbox_pprm u_sbox (
            .byte_in  (fifo_state[8*i +: 8]),
            .op       (fifo_op),
            .byte_out (sub_state[8*i +: 8])
        );
    end

    // ------------------------------------------------------------
    // Issue control
    // ------------------------------------------------------------

    logic [CRED_W-1:0] credit_cnt;
    logic              issue;

    // Head present and at least one downstream credit
    assign issue    = fifo_valid && (credit_cnt != '0);
    assign fifo_pop = issue;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= CRED_W'(OUT_CREDITS);
            out_valid  <= 1'b0;
        end else begin
            out_valid <= issue;
            // Spend on issue, refill on grant, net zero when both
            case ({issue, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------

    // Loaded only on issue
    always_ff @(posedge clk) begin
        if (issue) begin
            out_state <= sub_state;
            out_op    <= fifo_op;
        end
    end

endmodule

//--- verilog/sub_bytes_top.sv
// AES SubBytes engine top level
`timescale 1ns/1ps

module sub_bytes_top
    import aes_sbox_pkg::*;
#(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  sbox_op_e           in_op,
    input  logic [STATE_W-1:0] in_state,
    input  logic               out_credit,
    output logic               in_credit,
    output logic               out_valid,
    output sbox_op_e           out_op,
    output logic [STATE_W-1:0] out_state
);

    // ------------------------------------------------------------
    // Buffer head to datapath
    // ------------------------------------------------------------

    logic               fifo_valid;
    sbox_op_e           fifo_op;
    logic [STATE_W-1:0] fifo_state;
    logic               fifo_pop;

    // Input buffer, upstream credits returned here
    state_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_state_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_state   (in_state),
        .fifo_pop   (fifo_pop),
        .fifo_valid (fifo_valid),
        .fifo_op    (fifo_op),
        .fifo_state (fifo_state),
        .in_credit  (in_credit)
    );

    // S-box lanes, downstream credits held here
    sub_bytes_pipe #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_sub_bytes_pipe (
        .clk        (clk),
        .arst_n     (arst_n),
        .fifo_valid (fifo_valid),
        .fifo_op    (fifo_op),
        .fifo_state (fifo_state),
        .out_credit (out_credit),
        .fifo_pop   (fifo_pop),
        .out_valid  (out_valid),
        .out_op     (out_op),
        .out_state  (out_state)
    );

endmodule

//--- sim/sub_bytes_asserts.sv
// Credit protocol assertions
`timescale 1ns/1ps

module sub_bytes_asserts #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit
);

    // ------------------------------------------------------------
    // Credit shadows
    // ------------------------------------------------------------

    // Upstream credits still held by the sender
    int up_cred;

    // Downstream credits not yet used by a result
    int dn_cred;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            up_cred <= FIFO_DEPTH;
            dn_cred <= OUT_CREDITS;
        end else begin
            up_cred <= up_cred - (in_valid ? 1 : 0) + (in_credit ? 1 : 0);
            dn_cred <= dn_cred - (out_valid ? 1 : 0) + (out_credit ? 1 : 0);
        end
    end

    // ------------------------------------------------------------
    // Properties
    // ------------------------------------------------------------

    a_in_credit: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> up_cred > 0)
        else $error("in_valid sent with no upstream credit");

    a_out_credit: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> dn_cred > 0)
        else $error("out_valid sent with no downstream credit");

    // Handshake outputs stay known once out of reset
    a_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({out_valid, in_credit}))
        else $error("out_valid or in_credit unknown");

endmodule

bind sub_bytes_top sub_bytes_asserts #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) u_sub_bytes_asserts (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit)
);

//--- sim/tb_sub_bytes.sv
// SubBytes engine testbench
`timescale 1ns/1ps

module tb_sub_bytes
    import aes_sbox_pkg::*;
();

    localparam int FIFO_DEPTH  = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_ROWS      = 8;
    localparam int N_SWEEP     = 32;
    localparam int BP_ITEMS    = FIFO_DEPTH + OUT_CREDITS + 3;
    localparam int BP_HOLD     = 20;
    localparam int N_RAND      = 48;
    localparam int TIMEOUT_CYCLES = (N_ROWS + N_SWEEP + BP_ITEMS + N_RAND) * 40;

    // Downstream credit patterns
    localparam int PAT_OFF  = 0;
    localparam int PAT_ON   = 1;
    localparam int PAT_LFSR = 2;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               in_valid;
    sbox_op_e           in_op;
    logic [STATE_W-1:0] in_state;
    logic               out_credit = 1'b0;
    logic               in_credit;
    logic               out_valid;
    sbox_op_e           out_op;
    logic [STATE_W-1:0] out_state;

    // Stimulus table
    string              row_name  [N_ROWS];
    sbox_op_e           row_op    [N_ROWS];
    logic [STATE_W-1:0] row_state [N_ROWS];
    logic [STATE_W-1:0] row_exp   [N_ROWS];
    int                 row_pat   [N_ROWS];

    // Expected results in issue order
    string              exp_name_q  [$];
    sbox_op_e           exp_op_q    [$];
    logic [STATE_W-1:0] exp_state_q [$];

    int          sent_total   = 0;
    int          credits_back = 0;
    int          results      = 0;
    int          owed         = 0;
    int          cred_mode    = PAT_ON;
    logic        bp_done      = 1'b0;
    logic [31:0] data_lfsr    = 32'hdf97;
    logic [31:0] cred_lfsr    = 32'hdf97;

    always #5 clk = ~clk;

    sub_bytes_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_sub_bytes_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_state   (in_state),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_op     (out_op),
        .out_state  (out_state)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // Shift and add reduced by 0x11b
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] aa;
        acc = 8'h00;
        aa  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ aa;
            end
            aa = aa[7] ? ((aa << 1) ^ 8'h1b) : (aa << 1);
        end
        return acc;
    endfunction

    // Brute force search over all candidates
    // Zero has no inverse and maps to zero
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] r;
        r = 8'h00;
        for (int c = 1; c < 256; c++) begin
            if (gf_mul(a, 8'(c)) == 8'h01) begin
                r = 8'(c);
            end
        end
        return r;
    endfunction

    // Circulant matrix, each row the previous one rotated left
    function automatic logic [7:0] affine(input logic [7:0] a, input logic [7:0] row0,
                                          input logic [7:0] c);
        logic [7:0] row;
        logic [7:0] r;
        row = row0;
        for (int i = 0; i < 8; i++) begin
            r[i] = (^(row & a)) ^ c[i];
            row  = {row[6:0], row[7]};
        end
        return r;
    endfunction

    // Forward row 0 is 8'hf1
    // Inverse row 0 is 8'ha4
    function automatic logic [STATE_W-1:0] sub_ref(input logic [STATE_W-1:0] st,
                                                   input sbox_op_e op);
        logic [STATE_W-1:0] r;
        for (int i = 0; i < STATE_BYTES; i++) begin
            if (op == OP_SUB) begin
                r[8*i +: 8] = affine(gf_inv(st[8*i +: 8]), 8'hf1, AFFINE_C);
            end else begin
                r[8*i +: 8] = gf_inv(affine(st[8*i +: 8], 8'ha4, INV_AFFINE_C));
            end
        end
        return r;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [STATE_W-1:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            data_lfsr = lfsr_next(data_lfsr);
            v[b]      = data_lfsr[0];
        end
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------

    task automatic check_state(input string name, input logic [STATE_W-1:0] expected,
                               input logic [STATE_W-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "state mismatch");
        end
    endtask

    task automatic check_op(input string name, input sbox_op_e expected, input sbox_op_e actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %s actual %s", name, expected.name(), actual.name());
            $display("Some tests failed");
            $fatal(1, "opcode mismatch");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail %s: expected %0d actual %0d", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "count mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Upstream, downstream and monitor
    // ------------------------------------------------------------

    // FIPS-197 pairs 00/63 53/ed 01/7c ff/16
    // Each pair rotated through all lanes
    task automatic build_table();
        logic [31:0] w_in;
        logic [31:0] w_out;
        w_in  = 32'hff01_5300;
        w_out = 32'h167c_ed63;
        for (int r = 0; r < 4; r++) begin
            row_name[2*r]    = $sformatf("fips_sub_rot%0d", r);
            row_op[2*r]      = OP_SUB;
            row_state[2*r]   = {4{w_in}};
            row_exp[2*r]     = {4{w_out}};
            row_pat[2*r]     = (r % 2 == 0) ? PAT_ON : PAT_LFSR;
            row_name[2*r+1]  = $sformatf("fips_inv_rot%0d", r);
            row_op[2*r+1]    = OP_INV_SUB;
            row_state[2*r+1] = {4{w_out}};
            row_exp[2*r+1]   = {4{w_in}};
            row_pat[2*r+1]   = row_pat[2*r];
            w_in  = {w_in[23:0], w_in[31:24]};
            w_out = {w_out[23:0], w_out[31:24]};
        end
    endtask

    // Called 1 ns after an edge
    // Returns at the same phase
    task automatic send_item(input string name, input sbox_op_e op,
                             input logic [STATE_W-1:0] st, input logic [STATE_W-1:0] expected);
        // Hold off while no upstream credit is left
        while (FIFO_DEPTH - sent_total + credits_back <= 0) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_op    = op;
        in_state = st;
        exp_name_q.push_back(name);
        exp_op_q.push_back(op);
        exp_state_q.push_back(expected);
        sent_total = sent_total + 1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Until every result is in and every owed credit has landed
    task automatic wait_drain();
        while (exp_state_q.size() != 0 || owed != 0) begin
            @(posedge clk);
            #3;
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    // Downstream returns one credit per consumed result
    always @(posedge clk) begin
        logic grant;
        grant = 1'b0;
        if (arst_n && out_valid) begin
            owed = owed + 1;
        end
        if (owed != 0) begin
            if (cred_mode == PAT_ON) begin
                grant = 1'b1;
            end else if (cred_mode == PAT_LFSR) begin
                cred_lfsr = lfsr_next(cred_lfsr);
                grant     = cred_lfsr[0];
            end
        end
        if (grant) begin
            owed = owed - 1;
        end
        #1;
        out_credit = grant;
    end

    // In order check against the expected queue
    always @(posedge clk) begin
        if (arst_n && out_valid) begin
            if (exp_state_q.size() == 0) begin
                $display("Result arrived with no item outstanding");
                $display("Some tests failed");
                $fatal(1, "unexpected result");
            end else begin
                check_state(exp_name_q[0], exp_state_q[0], out_state);
                check_op(exp_name_q[0], exp_op_q[0], out_op);
                void'(exp_name_q.pop_front());
                void'(exp_op_q.pop_front());
                void'(exp_state_q.pop_front());
                results = results + 1;
            end
        end
        if (arst_n && in_credit) begin
            credits_back = credits_back + 1;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, results stopped arriving", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        logic [STATE_W-1:0] st;
        logic [STATE_W-1:0] bits;
        sbox_op_e           op;
        int                 res_base;
        int                 sent_base;
        int                 cred_base;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_op    = OP_SUB;
        in_state = '0;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Known answers from the table
        for (int r = 0; r < N_ROWS; r++) begin
            cred_mode = row_pat[r];
            send_item(row_name[r], row_op[r], row_state[r], row_exp[r]);
        end
        wait_drain();

        // Every byte value in both directions
        cred_mode = PAT_ON;
        for (int d = 0; d < 2; d++) begin
            op = (d == 0) ? OP_SUB : OP_INV_SUB;
            for (int k = 0; k < 16; k++) begin
                for (int i = 0; i < STATE_BYTES; i++) begin
                    st[8*i +: 8] = 8'(16 * k + i);
                end
                send_item((d == 0) ? "sweep_sub" : "sweep_inv", op, st, sub_ref(st, op));
            end
        end
        wait_drain();

        // Back-pressure with downstream credits withheld
        cred_mode = PAT_OFF;
        res_base  = results;
        sent_base = sent_total;
        cred_base = credits_back;
        fork
            begin
                logic [STATE_W-1:0] v;
                for (int n = 0; n < BP_ITEMS; n++) begin
                    draw_bits(STATE_W, v);
                    send_item("backpressure", OP_SUB, v, sub_ref(v, OP_SUB));
                end
                bp_done = 1'b1;
            end
        join_none
        while (sent_total - sent_base < FIFO_DEPTH + OUT_CREDITS) begin
            @(posedge clk);
            #3;
        end
        // Sender must stay stalled over this window
        repeat (BP_HOLD) @(posedge clk);
        #3;
        check_count("bp_stall_sent", FIFO_DEPTH + OUT_CREDITS, sent_total - sent_base);
        check_count("bp_results", OUT_CREDITS, results - res_base);
        // Only the issued items have freed a slot
        check_count("bp_stall_credits", OUT_CREDITS, credits_back - cred_base);
        cred_mode = PAT_ON;
        while (!bp_done) begin
            @(posedge clk);
            #3;
        end
        wait_drain();
        check_count("bp_credits", BP_ITEMS, credits_back - cred_base);

        // Random states, mixed opcodes, gated credits
        cred_mode = PAT_LFSR;
        for (int n = 0; n < N_RAND; n++) begin
            draw_bits(1, bits);
            op = sbox_op_e'(bits[0]);
            draw_bits(STATE_W, st);
            send_item("random", op, st, sub_ref(st, op));
        end
        wait_drain();
        check_count("in_credit_total", sent_total, credits_back);

        $display("All tests passed");
        $finish;
    end

endmodule

//--- all.f
verilog/aes_sbox_pkg.sv
verilog/pprm_inverter.sv
verilog/sbox_pprm.sv
verilog/state_fifo.sv
verilog/sub_bytes_pipe.sv
verilog/sub_bytes_top.sv
sim/sub_bytes_asserts.sv
sim/tb_sub_bytes.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sub_bytes -Mdir obj_dir -f all.f

status=0
out=$(./obj_dir/Vtb_sub_bytes 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
    exit 0
fi
echo "simulation exit status $status"
exit 1
